// File: issue_core.f
+incdir+testbench
source/issue_pkg.sv
source/issue_queue.sv
source/alu_unit.sv
source/issue_stage_top.sv
testbench/issue_stage_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f issue_core.f --top-module issue_stage_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vissue_stage_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: testbench/issue_stage_tb_model.svh
// known values by tag, filled as broadcasts go by
logic [data_width-1:0] tag_value [16];
logic                  tag_known [16];
logic [31:0]           lcg_state;

// per destination tag 0 to 7
logic                  dest_busy [8];
alu_op_t               dest_op   [8];
logic                  rs_known  [8];
logic [tag_width-1:0]  rs_wait   [8];
logic [data_width-1:0] rs_val    [8];
logic                  rt_known  [8];
logic [tag_width-1:0]  rt_wait   [8];
logic [data_width-1:0] rt_val    [8];

// external tags 8 to 15 still owed a commit
logic                  ext_pending [8];

function automatic logic [data_width-1:0] apply_op(
    input alu_op_t               op,
    input logic [data_width-1:0] a,
    input logic [data_width-1:0] b
);
    logic [data_width-1:0] res;
    case (op)
        op_add:
        begin
            res = a + b;
        end
        op_sub:
        begin
            res = a - b;
        end
        op_and:
        begin
            res = a & b;
        end
        default:
        begin
            res = a ^ b;
        end
    endcase
    return res;
endfunction

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// File: testbench/issue_stage_tb.sv
module issue_stage_tb
    import issue_pkg::*;
();

    logic                  clk_in;
    logic                  reset_in;
    logic                  alu_enable;
    logic                  dispatch_valid;
    alu_op_t               dispatch_op;
    logic [tag_width-1:0]  dispatch_dest_tag;
    logic                  dispatch_rs_ready;
    logic [tag_width-1:0]  dispatch_rs_tag;
    logic [data_width-1:0] dispatch_rs_value;
    logic                  dispatch_rt_ready;
    logic [tag_width-1:0]  dispatch_rt_tag;
    logic [data_width-1:0] dispatch_rt_value;
    logic                  commit_valid;
    logic [tag_width-1:0]  commit_tag;
    logic [data_width-1:0] commit_value;
    logic                  full;
    logic                  result_valid;
    logic [tag_width-1:0]  result_tag;
    logic [data_width-1:0] result_value;

    int   errors;
    int   results_seen;
    int   dispatched_total;
    int   cycle_count;
    int   inflight_count;
    int   last_wait_ext;
    int   disp_cycle [8];
    logic alu_en_req;
    logic check_latency;

    `include "issue_stage_tb_model.svh"

    issue_stage_top uut (.*);

    always #20 clk_in = ~clk_in;

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = lcg_next();
        return (r >> 16) % n;
    endfunction

    function automatic logic [data_width-1:0] rand_value();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = lcg_next();
        r2 = lcg_next();
        return {r1[31:16], r2[31:16]};
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int e = 0; e < 8; e++)
        begin
            if (ext_pending[e])
            begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_value(
        input logic [data_width-1:0] got,
        input logic [data_width-1:0] expected,
        input string                 what
    );
        if (got !== expected)
        begin
            errors++;
            $display("Fail at time %0t: %s, got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    // a broadcast wakes every model entry waiting on the tag
    task automatic resolve_tag(
        input logic [tag_width-1:0]  tag,
        input logic [data_width-1:0] value
    );
        tag_value[tag] = value;
        tag_known[tag] = 1'b1;
        for (int d = 0; d < 8; d++)
        begin
            if (dest_busy[d] && !rs_known[d] && rs_wait[d] == tag)
            begin
                rs_known[d] = 1'b1;
                rs_val[d]   = value;
            end
            if (dest_busy[d] && !rt_known[d] && rt_wait[d] == tag)
            begin
                rt_known[d] = 1'b1;
                rt_val[d]   = value;
            end
        end
    endtask

    // kind 0 is a ready value while 1 waits on an external tag and 2 on a producer
    task automatic pick_source(
        input  int                    kind,
        output logic                  rdy,
        output logic [tag_width-1:0]  tag,
        output logic [data_width-1:0] value
    );
        int e;
        int start;
        int found;
        rdy   = 1'b1;
        tag   = '0;
        value = rand_value();
        if (kind == 1)
        begin
            e = int'(rand_below(8));
            ext_pending[e] = 1'b1;
            last_wait_ext = e;
            rdy = 1'b0;
            tag = tag_width'(8 + e);
        end
        else if (kind == 2)
        begin
            start = int'(rand_below(8));
            found = -1;
            for (int i = 7; i >= 0; i--)
            begin
                if (dest_busy[(start + i) % 8])
                begin
                    found = (start + i) % 8;
                end
            end
            if (found >= 0)
            begin
                rdy = 1'b0;
                tag = tag_width'(found);
            end
            else if (tag_known[start])
            begin
                // a finished producer hands over its old value
                tag   = tag_width'(start);
                value = tag_value[start];
            end
        end
    endtask

    task automatic drive_dispatch(input alu_op_t op, input int rs_kind, input int rt_kind);
        logic                  rs_r;
        logic                  rt_r;
        logic [tag_width-1:0]  rs_t;
        logic [tag_width-1:0]  rt_t;
        logic [data_width-1:0] rs_v;
        logic [data_width-1:0] rt_v;
        int                    start;
        int                    d;
        pick_source(rs_kind, rs_r, rs_t, rs_v);
        pick_source(rt_kind, rt_r, rt_t, rt_v);
        start = int'(rand_below(8));
        d = 0;
        for (int i = 7; i >= 0; i--)
        begin
            if (!dest_busy[(start + i) % 8])
            begin
                d = (start + i) % 8;
            end
        end
        dest_busy[d] = 1'b1;
        dest_op[d]   = op;
        rs_known[d]  = rs_r;
        rs_wait[d]   = rs_t;
        rs_val[d]    = rs_v;
        rt_known[d]  = rt_r;
        rt_wait[d]   = rt_t;
        rt_val[d]    = rt_v;
        disp_cycle[d] = cycle_count;
        inflight_count++;
        dispatched_total++;
        dispatch_valid    <= 1'b1;
        dispatch_op       <= op;
        dispatch_dest_tag <= tag_width'(d);
        dispatch_rs_ready <= rs_r;
        dispatch_rs_tag   <= rs_t;
        dispatch_rs_value <= rs_v;
        dispatch_rt_ready <= rt_r;
        dispatch_rt_tag   <= rt_t;
        dispatch_rt_value <= rt_v;
    endtask

    // -1 picks a random pending tag and -2 the last one waited on
    task automatic drive_commit(input int which);
        int                    e;
        int                    start;
        logic [data_width-1:0] v;
        e = (which == -2) ? last_wait_ext : which;
        if (which == -1)
        begin
            start = int'(rand_below(8));
            for (int i = 7; i >= 0; i--)
            begin
                if (ext_pending[(start + i) % 8])
                begin
                    e = (start + i) % 8;
                end
            end
        end
        if (e >= 0)
        begin
            v = rand_value();
            ext_pending[e] = 1'b0;
            commit_valid <= 1'b1;
            commit_tag   <= tag_width'(8 + e);
            commit_value <= v;
            resolve_tag(tag_width'(8 + e), v);
        end
    endtask

    task automatic observe_result();
        int                    d;
        logic [data_width-1:0] model_value;
        if (result_valid === 1'b1)
        begin
            d = int'(result_tag[2:0]);
            if (result_tag[3] || !dest_busy[d])
            begin
                errors++;
                $display("Fail at time %0t: result for tag %0d not in flight", $time, result_tag);
            end
            else
            begin
                model_value = apply_op(dest_op[d], rs_val[d], rt_val[d]);
                check_value(data_width'(rs_known[d] & rt_known[d]), 1, "operands known");
                check_value(result_value, model_value, $sformatf("value of tag %0d", d));
                if (check_latency)
                begin
                    check_value(data_width'(cycle_count - disp_cycle[d]), 3, "result latency");
                end
                dest_busy[d] = 1'b0;
                inflight_count--;
                results_seen++;
                resolve_tag(tag_width'(d), model_value);
            end
        end
    endtask

    // drive on the rising edge and sample on the falling edge
    task automatic run_cycle(
        input logic    disp,
        input alu_op_t op,
        input int      rs_kind,
        input int      rt_kind,
        input logic    commit,
        input int      which
    );
        @(posedge clk_in);
        cycle_count++;
        dispatch_valid <= 1'b0;
        commit_valid   <= 1'b0;
        alu_enable     <= alu_en_req;
        if (disp)
        begin
            drive_dispatch(op, rs_kind, rt_kind);
        end
        if (commit)
        begin
            drive_commit(which);
        end
        @(negedge clk_in);
        observe_result();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            run_cycle(1'b0, op_add, 0, 0, 1'b0, -1);
        end
    endtask

    task automatic drain_all(input int limit);
        int n;
        alu_en_req = 1'b1;
        n = 0;
        while ((inflight_count > 0 || pending_count() > 0) && n < limit)
        begin
            run_cycle(1'b0, op_add, 0, 0, pending_count() > 0, -1);
            n++;
        end
        if (inflight_count > 0)
        begin
            errors++;
            $display("timeout while waiting for %0d instructions to drain", inflight_count);
        end
    endtask

    task automatic wait_full_low(input int limit);
        int n;
        n = 0;
        while (full && n < limit)
        begin
            idle_cycles(1);
            n++;
        end
        if (full)
        begin
            errors++;
            $display("timeout while waiting for the queue to leave full");
        end
    endtask

    initial
    begin
        #(40 * 100000);
        $display("simulation watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        int      start;
        logic    d;
        logic    c;
        alu_op_t op;
        clk_in = 1'b0;
        reset_in = 1'b1;
        alu_enable = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op = op_add;
        dispatch_dest_tag = '0;
        dispatch_rs_ready = 1'b0;
        dispatch_rs_tag = '0;
        dispatch_rs_value = '0;
        dispatch_rt_ready = 1'b0;
        dispatch_rt_tag = '0;
        dispatch_rt_value = '0;
        commit_valid = 1'b0;
        commit_tag = '0;
        commit_value = '0;
        errors = 0;
        results_seen = 0;
        dispatched_total = 0;
        cycle_count = 0;
        inflight_count = 0;
        last_wait_ext = 0;
        alu_en_req = 1'b1;
        check_latency = 1'b0;
        lcg_state = 32'd60;
        for (int i = 0; i < 16; i++)
        begin
            tag_value[i] = '0;
            tag_known[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++)
        begin
            dest_busy[i] = 1'b0;
            ext_pending[i] = 1'b0;
            disp_cycle[i] = 0;
        end
        repeat (10) @(posedge clk_in);
        reset_in <= 1'b0;
        @(negedge clk_in);
        check_value(data_width'(full), 0, "full after reset");
        check_value(data_width'(result_valid), 0, "result_valid after reset");

        // one ready dispatch per opcode with fixed latency
        check_latency = 1'b1;
        for (int k = 0; k < 4; k++)
        begin
            run_cycle(1'b1, alu_op_t'(2'(k)), 0, 0, 1'b0, -1);
            drain_all(20);
        end
        check_latency = 1'b0;

        // commit wake-up with the last commit in the dispatch cycle
        start = results_seen;
        run_cycle(1'b1, op_add, 1, 0, 1'b0, -1);
        run_cycle(1'b1, op_xor, 1, 1, 1'b0, -1);
        idle_cycles(8);
        check_value(data_width'(results_seen), data_width'(start), "results before commit");
        run_cycle(1'b1, op_sub, 1, 0, 1'b1, -2);
        drain_all(200);
        check_value(data_width'(results_seen), data_width'(start + 3), "commit wake-up results");

        // producer chain over the result bus
        start = results_seen;
        alu_en_req = 1'b0;
        run_cycle(1'b1, op_add, 0, 0, 1'b0, -1);
        run_cycle(1'b1, op_sub, 2, 0, 1'b0, -1);
        run_cycle(1'b1, op_and, 2, 2, 1'b0, -1);
        run_cycle(1'b1, op_xor, 0, 2, 1'b0, -1);
        run_cycle(1'b1, op_add, 2, 2, 1'b0, -1);
        drain_all(200);
        check_value(data_width'(results_seen), data_width'(start + 5), "chain results");

        // back-pressure
        start = results_seen;
        alu_en_req = 1'b0;
        for (int k = 0; k < 6; k++)
        begin
            run_cycle(1'b1, alu_op_t'(2'(k % 4)), 0, 0, 1'b0, -1);
        end
        idle_cycles(4);
        check_value(data_width'(full), 1, "full after six dispatches");
        check_value(data_width'(results_seen), data_width'(start), "results with alu disabled");
        alu_en_req = 1'b1;
        wait_full_low(10);
        // the first issue frees a slot one cycle before its result
        check_value(data_width'(results_seen), data_width'(start), "results when full falls");
        drain_all(100);
        check_value(data_width'(results_seen), data_width'(start + 6), "drained results");

        // random mix
        for (int k = 0; k < 600; k++)
        begin
            if (rand_below(8) == 0)
            begin
                alu_en_req = !alu_en_req;
            end
            d = (inflight_count < 6) && (rand_below(2) == 0);
            c = (pending_count() > 0) && (rand_below(3) == 0);
            op = alu_op_t'(2'(rand_below(4)));
            run_cycle(d, op, int'(rand_below(3)), int'(rand_below(3)), c, -1);
        end
        drain_all(400);

        check_value(data_width'(results_seen), data_width'(dispatched_total), "total results");
        $display("errors: %0d, dispatched: %0d, results: %0d",
            errors, dispatched_total, results_seen);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: source/issue_stage_top.sv
module issue_stage_top
    import issue_pkg::*;
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    input  logic                  alu_enable,

    input  logic                  dispatch_valid,
    input  alu_op_t               dispatch_op,
    input  logic [tag_width-1:0]  dispatch_dest_tag,
    input  logic                  dispatch_rs_ready,
    input  logic [tag_width-1:0]  dispatch_rs_tag,
    input  logic [data_width-1:0] dispatch_rs_value,
    input  logic                  dispatch_rt_ready,
    input  logic [tag_width-1:0]  dispatch_rt_tag,
    input  logic [data_width-1:0] dispatch_rt_value,

    input  logic                  commit_valid,
    input  logic [tag_width-1:0]  commit_tag,
    input  logic [data_width-1:0] commit_value,

    output logic                  full,

    output logic                  result_valid,
    output logic [tag_width-1:0]  result_tag,
    output logic [data_width-1:0] result_value
);

    // queue to alu
    logic                  issue_valid;
    alu_op_t               issue_op;
    logic [tag_width-1:0]  issue_dest_tag;
    logic [data_width-1:0] issue_rs_value;
    logic [data_width-1:0] issue_rt_value;

    issue_queue u_issue_queue
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .alu_enable        (alu_enable),
        .dispatch_valid    (dispatch_valid),
        .dispatch_op       (dispatch_op),
        .dispatch_dest_tag (dispatch_dest_tag),
        .dispatch_rs_ready (dispatch_rs_ready),
        .dispatch_rs_tag   (dispatch_rs_tag),
        .dispatch_rs_value (dispatch_rs_value),
        .dispatch_rt_ready (dispatch_rt_ready),
        .dispatch_rt_tag   (dispatch_rt_tag),
        .dispatch_rt_value (dispatch_rt_value),
        .commit_valid      (commit_valid),
        .commit_tag        (commit_tag),
        .commit_value      (commit_value),
        // result bus looped back as the execute bypass
        .result_valid      (result_valid),
        .result_tag        (result_tag),
        .result_value      (result_value),
        .full              (full),
        .issue_valid       (issue_valid),
        .issue_op          (issue_op),
        .issue_dest_tag    (issue_dest_tag),
        .issue_rs_value    (issue_rs_value),
        .issue_rt_value    (issue_rt_value)
    );

    alu_unit u_alu_unit
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_dest_tag (issue_dest_tag),
        .issue_rs_value (issue_rs_value),
        .issue_rt_value (issue_rt_value),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_value   (result_value)
    );

endmodule

// File: source/alu_unit.sv
module alu_unit
    import issue_pkg::*;
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    input  logic                  issue_valid,
    input  alu_op_t               issue_op,
    input  logic [tag_width-1:0]  issue_dest_tag,
    input  logic [data_width-1:0] issue_rs_value,
    input  logic [data_width-1:0] issue_rt_value,

    output logic                  result_valid,
    output logic [tag_width-1:0]  result_tag,
    output logic [data_width-1:0] result_value
);

    logic [data_width-1:0] alu_out;

    always_comb
    begin
        case (issue_op)
            op_add:
            begin
                alu_out = issue_rs_value + issue_rt_value;
            end
            op_sub:
            begin
                // wraps modulo 2^32
                alu_out = issue_rs_value - issue_rt_value;
            end
            op_and:
            begin
                alu_out = issue_rs_value & issue_rt_value;
            end
            default:
            begin
                alu_out = issue_rs_value ^ issue_rt_value;
            end
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= issue_valid;
        end
    end

    // payload only moves with a valid issue
    always_ff @(posedge clk_in)
    begin
        if (issue_valid)
        begin
            result_tag   <= issue_dest_tag;
            result_value <= alu_out;
        end
    end

endmodule

// File: source/issue_queue.sv
module issue_queue
    import issue_pkg::*;
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    input  logic                  alu_enable,

    // dispatch side
    input  logic                  dispatch_valid,
    input  alu_op_t               dispatch_op,
    input  logic [tag_width-1:0]  dispatch_dest_tag,
    input  logic                  dispatch_rs_ready,
    input  logic [tag_width-1:0]  dispatch_rs_tag,
    input  logic [data_width-1:0] dispatch_rs_value,
    input  logic                  dispatch_rt_ready,
    input  logic [tag_width-1:0]  dispatch_rt_tag,
    input  logic [data_width-1:0] dispatch_rt_value,

    // broadcast from the reorder buffer
    input  logic                  commit_valid,
    input  logic [tag_width-1:0]  commit_tag,
    input  logic [data_width-1:0] commit_value,

    // execute bypass from the alu
    input  logic                  result_valid,
    input  logic [tag_width-1:0]  result_tag,
    input  logic [data_width-1:0] result_value,

    output logic                  full,

    output logic                  issue_valid,
    output alu_op_t               issue_op,
    output logic [tag_width-1:0]  issue_dest_tag,
    output logic [data_width-1:0] issue_rs_value,
    output logic [data_width-1:0] issue_rt_value
);

    // entry state
    logic [num_entries-1:0] busy;
    logic [num_entries-1:0] rs_ready;
    logic [num_entries-1:0] rt_ready;

    alu_op_t               op_q       [num_entries];
    logic [tag_width-1:0]  dest_tag_q [num_entries];
    logic [tag_width-1:0]  rs_tag     [num_entries];
    logic [tag_width-1:0]  rt_tag     [num_entries];
    logic [data_width-1:0] rs_value   [num_entries];
    logic [data_width-1:0] rt_value   [num_entries];

    // operand after this cycle's broadcasts with the ready bit on top
    logic [data_width:0] rs_wake [num_entries];
    logic [data_width:0] rt_wake [num_entries];
    logic [data_width:0] disp_rs;
    logic [data_width:0] disp_rt;

    logic [slot_width-1:0]  alloc_idx;
    logic [num_entries-1:0] alloc_onehot;
    logic                   dispatch_fire;

    logic [num_entries-1:0] ready_vec;
    logic [slot_width-1:0]  sel_idx;
    logic [num_entries-1:0] issue_onehot;
    logic                   sel_found;
    logic                   issue_fire;

    // checks a waiting operand against both buses
    function automatic logic [data_width:0] wake_operand(
        input logic                  ready,
        input logic [tag_width-1:0]  tag,
        input logic [data_width-1:0] value
    );
        logic [data_width:0] next;
        next = {ready, value};
        if (!ready && commit_valid && (commit_tag == tag))
        begin
            next = {1'b1, commit_value};
        end
        else if (!ready && result_valid && (result_tag == tag))
        begin
            next = {1'b1, result_value};
        end
        return next;
    endfunction

    assign full = &busy;
    assign dispatch_fire = dispatch_valid && !full;

    // incoming operands may be woken in the dispatch cycle too
    always_comb
    begin
        disp_rs = wake_operand(dispatch_rs_ready, dispatch_rs_tag, dispatch_rs_value);
        disp_rt = wake_operand(dispatch_rt_ready, dispatch_rt_tag, dispatch_rt_value);
    end

    always_comb
    begin
        for (int i = 0; i < num_entries; i++)
        begin
            rs_wake[i] = wake_operand(rs_ready[i], rs_tag[i], rs_value[i]);
            rt_wake[i] = wake_operand(rt_ready[i], rt_tag[i], rt_value[i]);
        end
    end

    // lowest free slot
    always_comb
    begin
        alloc_idx = '0;
        for (int i = num_entries - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                alloc_idx = slot_width'(i);
            end
        end
        alloc_onehot = '0;
        if (dispatch_fire)
        begin
            alloc_onehot[alloc_idx] = 1'b1;
        end
    end

    assign ready_vec = busy & rs_ready & rt_ready;
    assign sel_found = |ready_vec;
    assign issue_fire = sel_found && alu_enable;

    // lowest ready slot wins
    always_comb
    begin
        sel_idx = '0;
        for (int i = num_entries - 1; i >= 0; i--)
        begin
            if (ready_vec[i])
            begin
                sel_idx = slot_width'(i);
            end
        end
        issue_onehot = '0;
        if (issue_fire)
        begin
            issue_onehot[sel_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            busy        <= '0;
            rs_ready    <= '0;
            rt_ready    <= '0;
            issue_valid <= 1'b0;
        end
        else
        begin
            issue_valid <= issue_fire;
            for (int i = 0; i < num_entries; i++)
            begin
                if (alloc_onehot[i])
                begin
                    busy[i]     <= 1'b1;
                    rs_ready[i] <= disp_rs[data_width];
                    rt_ready[i] <= disp_rt[data_width];
                end
                else if (busy[i])
                begin
                    rs_ready[i] <= rs_wake[i][data_width];
                    rt_ready[i] <= rt_wake[i][data_width];
                    // freed on the edge that loads the issue registers
                    if (issue_onehot[i])
                    begin
                        busy[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        for (int i = 0; i < num_entries; i++)
        begin
            if (alloc_onehot[i])
            begin
                op_q[i]       <= dispatch_op;
                dest_tag_q[i] <= dispatch_dest_tag;
                rs_tag[i]     <= dispatch_rs_tag;
                rt_tag[i]     <= dispatch_rt_tag;
                rs_value[i]   <= disp_rs[data_width-1:0];
                rt_value[i]   <= disp_rt[data_width-1:0];
            end
            else if (busy[i])
            begin
                rs_value[i] <= rs_wake[i][data_width-1:0];
                rt_value[i] <= rt_wake[i][data_width-1:0];
            end
        end

        if (issue_fire)
        begin
            issue_op       <= op_q[sel_idx];
            issue_dest_tag <= dest_tag_q[sel_idx];
            issue_rs_value <= rs_value[sel_idx];
            issue_rt_value <= rt_value[sel_idx];
        end
    end

endmodule

// File: source/issue_pkg.sv
package issue_pkg;

    // queue geometry
    localparam int num_entries = 6;
    localparam int slot_width = 3;

    // tags name producers, 16 in flight at most
    localparam int tag_width = 4;

    // operand and result width
    localparam int data_width = 32;

    // alu operations carried through the queue
    typedef enum logic [1:0]
    {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_and = 2'd2,
        op_xor = 2'd3
    } alu_op_t;

endpackage
